//--- src/bdHarnessPkg.sv
// --------------------
// BD harness shared definitions
// Host word tags, bus addresses and field types
// --------------------
package bdHarnessPkg;

  // Field types
  typedef logic [31:0] wordT;        // Host word in either direction
  typedef logic [15:0] regDataT;     // Register or channel value
  typedef logic [4:0]  regIdT;       // Register or channel index
  typedef logic [5:0]  bdCodeT;      // BD packet code
  typedef logic [19:0] bdPayloadT;   // BD packet payload
  typedef logic [33:0] upPacketT;    // Emulated from-BD packet
  typedef logic [23:0] fromBdLowT;   // First from-BD half
  typedef logic [1:0]  tagT;         // Top two bits of a downstream word
  typedef logic [7:0]  busAdrT;      // Wishbone word address
  typedef logic [7:0]  errCountT;    // Saturating protocol error count

  // --------------------
  // Downstream word tags
  localparam tagT tagToBd = 2'b00;
  localparam tagT tagReg  = 2'b10;
  localparam tagT tagChan = 2'b11;

  localparam logic [7:0] fromBdMark = 8'hFF;  // Whole top byte marks a from-BD half

  // Tag bytes of the two upstream words of one from-BD packet
  localparam logic [7:0] upTagLow  = 8'h01;
  localparam logic [7:0] upTagHigh = 8'h02;

  localparam int fieldLsb = 24;  // Code and index fields start here

  // --------------------
  // Bus map
  localparam busAdrT addrDown     = 8'h00;  // Downstream word write
  localparam busAdrT addrUp       = 8'h01;  // Upstream FIFO pop
  localparam busAdrT addrStatus   = 8'h02;
  localparam busAdrT addrRegBase  = 8'h20;  // 0x20..0x3F
  localparam busAdrT addrChanBase = 8'h40;  // 0x40..0x5F

  // Reserved padding register that discards writes
  localparam regIdT nopRegId = 5'd31;

endpackage

//--- src/hostBusSlave.sv
// --------------------
// Host bus slave
// Wishbone classic accesses to decoder, register and FIFO operations
// --------------------
module hostBusSlave #(
  parameter int upDepth = 16
) (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          wbCyc,
  input  logic                          wbStb,
  input  logic                          wbWe,
  input  bdHarnessPkg::busAdrT          wbAdr,
  input  bdHarnessPkg::wordT            wbDatW,
  output bdHarnessPkg::wordT            wbDatR,
  output logic                          wbAck,
  output logic                          downValid,
  output bdHarnessPkg::wordT            downWord,
  input  logic                          downTake,
  output logic                          rdBank,
  output bdHarnessPkg::regIdT           rdId,
  input  bdHarnessPkg::regDataT         rdData,
  output logic                          upPop,
  input  bdHarnessPkg::wordT            upWordOut,
  input  logic                          upEmpty,
  input  logic [$clog2(upDepth+1)-1:0]  upCount,
  input  bdHarnessPkg::errCountT        protoErrs
);
  import bdHarnessPkg::*;

  typedef enum logic [1:0] {sIdle, sDecode, sWaitTake, sAck} busStateT;

  busStateT state;
  busAdrT   adrQ;        // Address of the access in flight
  logic     weQ;
  wordT     datQ;        // Write data held for the decoder
  logic     isDown;
  logic     inRegBank;
  logic     inChanBank;
  wordT     statusWord;
  wordT     readWord;

  // Address decode on the latched request
  assign isDown     = weQ && (adrQ == addrDown);
  assign inRegBank  = adrQ[7:5] == addrRegBase[7:5];
  assign inChanBank = adrQ[7:5] == addrChanBase[7:5];

  assign rdBank   = inChanBank;   // Channel bank when set
  assign rdId     = adrQ[4:0];
  assign downWord = datQ;

  // Word stays offered until the decoder takes it
  assign downValid = isDown && (state == sDecode || state == sWaitTake);
  assign upPop     = (state == sDecode) && !weQ && (adrQ == addrUp) && !upEmpty;
  assign wbAck     = state == sAck;   // Single-cycle pulse

  assign statusWord = {8'h00, protoErrs, 16'(upCount)};

  // Read data select
  always_comb begin
    readWord = '0;  // Unmapped reads return zero
    if (adrQ == addrUp) begin
      if (!upEmpty) readWord = upWordOut;
    end else if (adrQ == addrStatus) begin
      readWord = statusWord;
    end else if (inRegBank || inChanBank) begin
      readWord = {16'h0000, rdData};
    end
  end

  // --------------------
  // Access FSM
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= sIdle;
      adrQ  <= '0;
      weQ   <= 1'b0;
    end else begin
      case (state)
        sIdle: begin
          if (wbCyc && wbStb) begin
            adrQ  <= wbAdr;
            weQ   <= wbWe;
            state <= sDecode;
          end
        end
        sDecode: state <= (!isDown || downTake) ? sAck : sWaitTake;
        sWaitTake: if (downTake) state <= sAck;   // Stretches under back-pressure
        sAck: state <= sIdle;
        default: state <= sIdle;
      endcase
    end
  end

  // Payload capture
  always_ff @(posedge clk) begin
    if (state == sIdle && wbCyc && wbStb) datQ <= wbDatW;
    if (state == sDecode && !weQ) wbDatR <= readWord;  // Ready with the ack
  end

endmodule

//--- src/downstreamDecoder.sv
// --------------------
// Downstream word decoder
// Routes host words to registers, the BD port and the upstream queue
// --------------------
module downstreamDecoder (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    downValid,
  input  bdHarnessPkg::wordT      downWord,
  output logic                    downTake,
  output logic                    bdValid,
  output bdHarnessPkg::bdCodeT    bdCode,
  output bdHarnessPkg::bdPayloadT bdPayload,
  input  logic                    bdReady,
  output logic                    regWe,
  output logic                    regBank,
  output bdHarnessPkg::regIdT     regId,
  output bdHarnessPkg::regDataT   regData,
  output logic                    upPush,
  output bdHarnessPkg::wordT      upWord,
  input  logic                    upFull,
  output bdHarnessPkg::errCountT  protoErrs
);
  import bdHarnessPkg::*;

  typedef enum logic [1:0] {dIdle, dBdWait, dPushHigh} decStateT;

  decStateT  state;
  logic      halfPending;   // Low from-BD half stored
  fromBdLowT lowHalfQ;
  wordT      hiWordQ;       // Second upstream word of a packet
  upPacketT  packet;
  tagT       tag;
  regIdT     idField;
  logic      isFromBd;
  logic      startBd;
  logic      startPair;

  assign tag      = downWord[31:30];
  assign idField  = downWord[fieldLsb +: $bits(regIdT)];
  assign isFromBd = downWord[31:24] == fromBdMark;   // Checked before the tag
  assign packet   = {downWord[9:0], lowHalfQ};       // Second half gives bits 33:24

  // --------------------
  // Take and push decisions
  always_comb begin
    downTake  = 1'b0;
    upPush    = 1'b0;
    upWord    = downWord;   // Echo of a to-BD word
    startBd   = 1'b0;
    startPair = 1'b0;
    case (state)
      dIdle: begin
        if (downValid) begin
          if (isFromBd) begin
            if (!halfPending) begin
              downTake = 1'b1;
            end else if (!upFull) begin
              upPush    = 1'b1;       // Low word first
              upWord    = {upTagLow, packet[23:0]};
              startPair = 1'b1;
            end
          end else if (tag == tagToBd) begin
            startBd = !upFull;        // Echo space is reserved here
          end else begin
            downTake = 1'b1;          // Register, channel or bad tag
          end
        end
      end
      dBdWait: begin
        if (bdReady) begin            // Transfer, take and echo together
          downTake = 1'b1;
          upPush   = 1'b1;
        end
      end
      dPushHigh: begin
        if (!upFull) begin
          downTake = 1'b1;
          upPush   = 1'b1;
          upWord   = hiWordQ;
        end
      end
      default: ;
    endcase
  end

  // Control state
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state       <= dIdle;
      bdValid     <= 1'b0;
      bdCode      <= '0;
      bdPayload   <= '0;
      halfPending <= 1'b0;
      regWe       <= 1'b0;
      protoErrs   <= '0;
    end else begin
      regWe <= 1'b0;
      case (state)
        dIdle: begin
          if (startBd) begin          // Valid rises the cycle after the word shows up
            state     <= dBdWait;
            bdValid   <= 1'b1;
            bdCode    <= downWord[fieldLsb +: $bits(bdCodeT)];
            bdPayload <= downWord[$bits(bdPayloadT)-1:0];
          end
          if (startPair) state <= dPushHigh;
          if (downTake) begin
            if (isFromBd) begin
              halfPending <= 1'b1;
            end else if (tag == tagReg || tag == tagChan) begin
              regWe <= !(tag == tagReg && idField == nopRegId);  // Drop padding writes
            end else if (protoErrs != '1) begin
              protoErrs <= protoErrs + 1'b1;                    // Saturates at 255
            end
          end
        end
        dBdWait: begin
          if (bdReady) begin
            bdValid <= 1'b0;
            state   <= dIdle;
          end
        end
        dPushHigh: begin
          if (!upFull) begin
            halfPending <= 1'b0;
            state       <= dIdle;
          end
        end
        default: state <= dIdle;
      endcase
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (state == dIdle && downTake) begin
      if (isFromBd) lowHalfQ <= downWord[23:0];
      regBank <= tag[0];
      regId   <= idField;
      regData <= downWord[$bits(regDataT)-1:0];
    end
    if (startPair) hiWordQ <= {upTagHigh, 14'h0000, packet[33:24]};
  end

endmodule

//--- src/configRegs.sv
// --------------------
// Configuration register store
// Register and channel banks of 32 16-bit entries
// --------------------
module configRegs (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  regWe,
  input  logic                  regBank,   // Set for the channel bank
  input  bdHarnessPkg::regIdT   regId,
  input  bdHarnessPkg::regDataT regData,
  input  logic                  rdBank,
  input  bdHarnessPkg::regIdT   rdId,
  output bdHarnessPkg::regDataT rdData
);
  import bdHarnessPkg::*;

  localparam int numRegs = 2 ** $bits(regIdT);

  regDataT regMem  [numRegs];
  regDataT chanMem [numRegs];

  // --------------------
  // Write port
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      // Both banks start out zero
      for (int i = 0; i < numRegs; i++) begin
        regMem[i]  <= '0;
        chanMem[i] <= '0;
      end
    end else if (regWe) begin
      if (regBank) begin
        chanMem[regId] <= regData;
      end else begin
        regMem[regId] <= regData;
      end
    end
  end

  // --------------------
  // Combinational read port
  assign rdData = rdBank ? chanMem[rdId] : regMem[rdId];

endmodule

//--- src/upstreamFifo.sv
// --------------------
// Upstream word FIFO
// Circular buffer with a head view and occupancy count
// --------------------
module upstreamFifo #(
  parameter int upDepth = 16
) (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          upPush,
  input  bdHarnessPkg::wordT            upWord,
  input  logic                          upPop,
  output bdHarnessPkg::wordT            upWordOut,
  output logic                          upFull,
  output logic                          upEmpty,
  output logic [$clog2(upDepth+1)-1:0]  upCount
);
  import bdHarnessPkg::*;

  localparam int ptrW = (upDepth > 1) ? $clog2(upDepth) : 1;

  typedef logic [ptrW-1:0] ptrT;

  wordT mem [upDepth];
  ptrT  wrPtr;
  ptrT  rdPtr;
  logic doPush;
  logic doPop;

  // Pointer step that wraps at any depth
  function automatic ptrT nextPtr(input ptrT p);
    ptrT n;
    n = (p == ptrT'(upDepth - 1)) ? '0 : p + 1'b1;
    return n;
  endfunction

  assign upFull    = upCount == upDepth;
  assign upEmpty   = upCount == '0;
  assign doPush    = upPush && !upFull;    // Full push is lost here
  assign doPop     = upPop && !upEmpty;
  assign upWordOut = mem[rdPtr];           // Head word

  // --------------------
  // Pointers and count
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr   <= '0;
      rdPtr   <= '0;
      upCount <= '0;
    end else begin
      if (doPush) wrPtr <= nextPtr(wrPtr);
      if (doPop) rdPtr <= nextPtr(rdPtr);
      case ({doPush, doPop})
        2'b10: upCount <= upCount + 1'b1;
        2'b01: upCount <= upCount - 1'b1;
        default: ;   // Both or neither leave it
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (doPush) mem[wrPtr] <= upWord;
  end

endmodule

//--- src/bdHarnessTop.sv
// --------------------
// BD harness top
// Host bus slave, decoder, register store and upstream queue
// --------------------
module bdHarnessTop #(
  parameter int upDepth = 16
) (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    wbCyc,
  input  logic                    wbStb,
  input  logic                    wbWe,
  input  bdHarnessPkg::busAdrT    wbAdr,
  input  bdHarnessPkg::wordT      wbDatW,
  output bdHarnessPkg::wordT      wbDatR,
  output logic                    wbAck,
  output logic                    bdValid,
  output bdHarnessPkg::bdCodeT    bdCode,
  output bdHarnessPkg::bdPayloadT bdPayload,
  input  logic                    bdReady
);
  import bdHarnessPkg::*;

  // Host to decoder
  logic downValid;
  wordT downWord;
  logic downTake;

  // Register write and read
  logic    regWe;
  logic    regBank;
  regIdT   regId;
  regDataT regData;
  logic    rdBank;
  regIdT   rdId;
  regDataT rdData;

  // Upstream queue
  logic                         upPush;
  wordT                         upWord;
  logic                         upPop;
  wordT                         upWordOut;
  logic                         upFull;
  logic                         upEmpty;
  logic [$clog2(upDepth+1)-1:0] upCount;
  errCountT                     protoErrs;

  hostBusSlave #(.upDepth(upDepth)) uBus (
    .clk, .arstN, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbDatR, .wbAck,
    .downValid, .downWord, .downTake, .rdBank, .rdId, .rdData,
    .upPop, .upWordOut, .upEmpty, .upCount, .protoErrs
  );

  downstreamDecoder uDecoder (
    .clk, .arstN, .downValid, .downWord, .downTake,
    .bdValid, .bdCode, .bdPayload, .bdReady,
    .regWe, .regBank, .regId, .regData,
    .upPush, .upWord, .upFull, .protoErrs
  );

  configRegs uRegs (
    .clk, .arstN, .regWe, .regBank, .regId, .regData, .rdBank, .rdId, .rdData
  );

  upstreamFifo #(.upDepth(upDepth)) uUpFifo (
    .clk, .arstN, .upPush, .upWord, .upPop, .upWordOut, .upFull, .upEmpty, .upCount
  );

endmodule

//--- dv/bdHarness_properties.sv
// --------------------
// BD harness properties
// Bus ack and BD handshake rules bound into the top level
// --------------------
module bdHarnessProperties (
  input logic                    clk,
  input logic                    arstN,
  input logic                    wbStb,
  input logic                    wbAck,
  input logic                    bdValid,
  input logic                    bdReady,
  input bdHarnessPkg::bdCodeT    bdCode,
  input bdHarnessPkg::bdPayloadT bdPayload,
  input logic                    upPush,
  input logic                    upFull
);

  ackNeedsStb: assert property (@(posedge clk) disable iff (!arstN) wbAck |-> wbStb)
    else $error("wbAck high without wbStb");

  ackOneCycle: assert property (@(posedge clk) disable iff (!arstN) wbAck |=> !wbAck)
    else $error("wbAck wider than one cycle");

  // Offered packet holds until ready
  bdHold: assert property (@(posedge clk) disable iff (!arstN)
    bdValid && !bdReady |=> bdValid && $stable(bdCode) && $stable(bdPayload))
    else $error("BD packet changed before ready");

  pushNotFull: assert property (@(posedge clk) disable iff (!arstN) !(upPush && upFull))
    else $error("upstream push while FIFO full");

endmodule

bind bdHarnessTop bdHarnessProperties uProps (
  .clk, .arstN, .wbStb, .wbAck, .bdValid, .bdReady, .bdCode, .bdPayload, .upPush, .upFull
);

//--- dv/bdHarnessTb.sv
// --------------------
// BD harness testbench
// File-driven bus operations checked against a reference model
// --------------------
module bdHarnessTb;
  import bdHarnessPkg::*;

  localparam int clkHalf     = 2;
  localparam int cyclesPerOp = 200;   // Watchdog budget per test line

  logic      clk;
  logic      arstN;
  logic      wbCyc;
  logic      wbStb;
  logic      wbWe;
  busAdrT    wbAdr;
  wordT      wbDatW;
  wordT      wbDatR;
  logic      wbAck;
  logic      bdValid;
  bdCodeT    bdCode;
  bdPayloadT bdPayload;
  logic      bdReady;

  // Test table from the data file
  string       testName [$];
  string       testOp [$];
  logic [31:0] testAdr [$];
  logic [31:0] testDat [$];
  logic [31:0] testExp [$];
  int          numOps;

  // --------------------
  // Reference model
  logic [15:0] regModel [32];
  logic [15:0] chanModel [32];
  logic [31:0] upModel [$];     // Upstream words in order
  logic [25:0] bdModel [$];     // {code, payload} still to be sent
  int          errModel;
  logic        halfModel;       // Low from-BD half held
  logic [23:0] lowModel;

  int          errors;
  int          failedTests;
  int          stallLeft;       // Forced ready-low cycles left
  logic [31:0] lfsr;

  bdHarnessTop dut (
    .clk, .arstN, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbDatR, .wbAck,
    .bdValid, .bdCode, .bdPayload, .bdReady
  );

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  initial begin
    clk = 1'b0;
    forever #clkHalf clk = ~clk;
  end

  // BD ready is random unless a stall holds it low
  always @(posedge clk) begin
    logic [31:0] nextLfsr;
    if (stallLeft > 0) begin
      bdReady   <= 1'b0;
      stallLeft <= stallLeft - 1;
    end else begin
      nextLfsr = lfsrStep(lfsr);
      lfsr    <= nextLfsr;
      bdReady <= nextLfsr[0];   // One new bit per cycle
    end
  end

  // BD transfer monitor checks every cycle with valid and ready
  always @(negedge clk) begin
    logic [25:0] expPkt;
    if (arstN && bdValid && bdReady) begin
      if (bdModel.size() == 0) begin
        $display("Error at %0t: BD transfer %h with no packet pending", $time,
                 {bdCode, bdPayload});
        errors++;
      end else begin
        expPkt = bdModel.pop_front();
        if ({bdCode, bdPayload} !== expPkt) begin
          $display("Mismatch at %0t: bdCode,bdPayload expected %h got %h", $time,
                   expPkt, {bdCode, bdPayload});
          errors++;
        end
      end
    end
  end

  // --------------------
  // Bus and model tasks
  task automatic busAccess(input logic we, input busAdrT adr, input wordT datW,
                           output wordT datR, output logic ackInStall);
    @(posedge clk);
    wbCyc  <= 1'b1;
    wbStb  <= 1'b1;
    wbWe   <= we;
    wbAdr  <= adr;
    wbDatW <= datW;
    do begin
      @(negedge clk);
    end while (!wbAck);
    datR       = wbDatR;
    ackInStall = stallLeft > 0;
    @(posedge clk);          // Drop stb for a cycle
    wbCyc <= 1'b0;
    wbStb <= 1'b0;
    wbWe  <= 1'b0;
  endtask

  task automatic modelWrite(input logic [7:0] adr, input logic [31:0] w);
    logic [33:0] pkt;
    if (adr != 8'h00) return;  // Other addresses ignore writes
    if (w[31:24] == 8'hff) begin
      if (!halfModel) begin
        lowModel  = w[23:0];
        halfModel = 1'b1;
      end else begin
        pkt = {w[9:0], lowModel};
        upModel.push_back({8'h01, pkt[23:0]});
        upModel.push_back({8'h02, 14'h0000, pkt[33:24]});
        halfModel = 1'b0;
      end
    end else begin
      case (w[31:30])
        2'b00: begin
          bdModel.push_back({w[29:24], w[19:0]});
          upModel.push_back(w);      // Echo
        end
        2'b10: if (w[28:24] != 5'd31) regModel[w[28:24]] = w[15:0];
        2'b11: chanModel[w[28:24]] = w[15:0];
        default: if (errModel < 255) errModel++;
      endcase
    end
  endtask

  task automatic modelRead(input logic [7:0] adr, output logic [31:0] expWord);
    expWord = '0;
    if (adr == 8'h01) begin
      if (upModel.size() > 0) expWord = upModel.pop_front();
    end else if (adr == 8'h02) begin
      expWord = {8'h00, 8'(errModel), 16'(upModel.size())};
    end else if (adr >= 8'h20 && adr <= 8'h3f) begin
      expWord = {16'h0000, regModel[adr[4:0]]};
    end else if (adr >= 8'h40 && adr <= 8'h5f) begin
      expWord = {16'h0000, chanModel[adr[4:0]]};
    end
  endtask

  // Lines starting with # are comments
  task automatic loadTests();
    int          fd;
    int          n;
    string       line;
    string       name;
    string       op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    fd = $fopen("dv/bdHarnessTests.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open dv/bdHarnessTests.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%s %s %h %h %h", name, op, a, d, e);
      if (n != 5) begin
        $display("Error: malformed test line: %s", line);
        errors++;
        continue;
      end
      testName.push_back(name);
      testOp.push_back(op);
      testAdr.push_back(a);
      testDat.push_back(d);
      testExp.push_back(e);
    end
    $fclose(fd);
  endtask

  // --------------------
  // Main sequence
  initial begin
    logic [31:0] expWord;
    logic [31:0] rdWord;
    logic        ackInStall;
    int          errBefore;
    arstN     = 1'b0;
    wbCyc     = 1'b0;
    wbStb     = 1'b0;
    wbWe      = 1'b0;
    wbAdr     = '0;
    wbDatW    = '0;
    bdReady   = 1'b0;
    lfsr      = 32'h178f_d722;
    stallLeft = 0;
    errors    = 0;
    errModel  = 0;
    halfModel = 1'b0;
    for (int i = 0; i < 32; i++) begin
      regModel[i]  = '0;
      chanModel[i] = '0;
    end
    loadTests();
    numOps = testName.size();
    repeat (2) @(posedge clk);
    arstN <= 1'b1;

    for (int i = 0; i < numOps; i++) begin
      errBefore = errors;
      if (testOp[i] == "write") begin
        modelWrite(testAdr[i][7:0], testDat[i]);
        busAccess(1'b1, testAdr[i][7:0], testDat[i], rdWord, ackInStall);
        // A to-BD write must wait out the stall
        if (ackInStall && testAdr[i][7:0] == 8'h00 && testDat[i][31:30] == 2'b00) begin
          $display("Error at %0t: %s acked while BD ready was held low", $time, testName[i]);
          errors++;
        end
      end else if (testOp[i] == "read") begin
        modelRead(testAdr[i][7:0], expWord);
        busAccess(1'b0, testAdr[i][7:0], '0, rdWord, ackInStall);
        if (rdWord !== testExp[i]) begin
          $display("Mismatch at %0t: wbDatR expected %h got %h", $time, testExp[i], rdWord);
          errors++;
        end
        if (expWord !== testExp[i]) begin
          $display("Error: %s expects %h but the model predicts %h", testName[i],
                   testExp[i], expWord);
          errors++;
        end
      end else if (testOp[i] == "bdstall") begin
        @(posedge clk);
        stallLeft <= int'(testDat[i]);
      end else begin
        $display("Error: unknown operation %s in %s", testOp[i], testName[i]);
        errors++;
      end
      if (errors != errBefore) failedTests++;
      $display("%s %s", (errors == errBefore) ? "ok  " : "FAIL", testName[i]);
    end

    repeat (4) @(posedge clk);
    if (bdModel.size() != 0) begin
      $display("Error: %0d BD packets were never transferred", bdModel.size());
      errors++;
    end
    $display("Summary: %0d tests, %0d failed, %0d errors", numOps, failedTests, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // Watchdog sized from the test table
  initial begin
    wait (numOps > 0);
    repeat (numOps * cyclesPerOp) @(posedge clk);
    $display("Watchdog: run timed out after %0d cycles", numOps * cyclesPerOp);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- dv/bdHarnessTests.txt
# name op addr data expect, all numbers in hex
# bdstall holds BD ready low for data cycles, expect unused for writes
regWr write 00 8503a5a5 0
regRd read 25 0 0000a5a5
chanWr write 00 c3001234 0
chanRd read 43 0 00001234
nopWr write 00 9f00beef 0
nopRd read 3f 0 00000000
bdSend write 00 2a0abcde 0
statusA read 02 0 00000001
fbLow write 00 ff123456 0
fbHigh write 00 ff0003ab 0
popEcho read 01 0 2a0abcde
popLow read 01 0 01123456
popHigh read 01 0 020003ab
popEmpty read 01 0 00000000
stall bdstall 00 00000014 0
bdStalled write 00 05000042 0
bdAgain write 00 3f0fffff 0
statusB read 02 0 00000002
badTag write 00 40000000 0
badTag2 write 00 7fffffff 0
statusC read 02 0 00020002
popB1 read 01 0 05000042
popB2 read 01 0 3f0fffff
statusD read 02 0 00020000
unmapRd read 7f 0 00000000

//--- project.f
src/bdHarnessPkg.sv
src/hostBusSlave.sv
src/downstreamDecoder.sv
src/configRegs.sv
src/upstreamFifo.sv
src/bdHarnessTop.sv
dv/bdHarness_properties.sv
dv/bdHarnessTb.sv

//--- Makefile
# Verilator build and run of the BD harness testbench

SIM = obj_dir/VbdHarnessTb

all: run

$(SIM): project.f $(wildcard src/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module bdHarnessTb -f project.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
